//--- hdl/isa_pkg.sv
package isa_pkg;

    // instruction word widths
    localparam int opcode_bits = 8;
    localparam int data_bits = 8;

    // architectural registers
    localparam int num_regs = 4;
    localparam int reg_bits = $clog2(num_regs);

    // upstream queue, also the sender's starting credit count
    localparam int queue_depth = 4;
    localparam int queue_ptr_bits = $clog2(queue_depth);

    // credits the core holds for the output link after reset
    localparam int out_credits = 2;
    localparam int credit_bits = $clog2(out_credits + 1);

    // opcodes, anything outside 1..7 is invalid
    localparam logic [opcode_bits-1:0] OP_LDI = 8'h01;
    localparam logic [opcode_bits-1:0] OP_ADD = 8'h02;
    localparam logic [opcode_bits-1:0] OP_SUB = 8'h03;
    localparam logic [opcode_bits-1:0] OP_AND = 8'h04;
    localparam logic [opcode_bits-1:0] OP_XOR = 8'h05;
    localparam logic [opcode_bits-1:0] OP_SHL = 8'h06;
    localparam logic [opcode_bits-1:0] OP_OUT = 8'h07;

    typedef struct packed {
        logic [opcode_bits-1:0] opcode;
        logic [reg_bits-1:0] rd;
        logic [reg_bits-1:0] rs;
        logic [data_bits-1:0] imm;
    } instr_t;

endpackage

//--- hdl/ucode_pkg.sv
package ucode_pkg;

    localparam int addr_bits = 6;

    // fixed microcode addresses, opcode n dispatches to address n
    localparam logic [addr_bits-1:0] fetch_address = 6'h00;
    localparam logic [addr_bits-1:0] shl_loop_address = 6'h08;
    localparam logic [addr_bits-1:0] bad_opcode_address = 6'h10;

    typedef enum logic [1:0] {
        JUMP_UNCOND,
        // take the opcode of the queue head when it is valid
        JUMP_DISPATCH,
        // go to fetch once the shift counter runs out, otherwise to next
        JUMP_COUNT_ZERO
    } jump_type_t;

    typedef enum logic [2:0] {
        ALU_PASS_B,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR,
        ALU_SHL1
    } alu_op_t;

    typedef struct packed {
        logic [addr_bits-1:0] next;
        jump_type_t jump_type;
        alu_op_t alu_op;
        // operand b from the immediate instead of register rs
        logic b_imm;
        logic rd_write;
        // load the shift counter from imm
        logic count_load;
        logic out_write;
        logic next_instruction;
        logic fault;
    } ucode_word_t;

endpackage

//--- hdl/instr_queue.sv
`timescale 1ns/1ps

module instr_queue
    import isa_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic in_valid,
    input instr_t in_instr,
    output logic in_credit,
    output instr_t head,
    output logic head_valid,
    input logic pop
);

    instr_t mem [queue_depth];
    logic [queue_ptr_bits-1:0] rd_ptr;
    logic [queue_ptr_bits-1:0] wr_ptr;
    logic [queue_ptr_bits:0] count;

    assign head = mem[rd_ptr];
    assign head_valid = count != '0;

    always_ff @(posedge clk) begin
        if (in_valid)
            mem[wr_ptr] <= in_instr;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid)
                wr_ptr <= wr_ptr == queue_ptr_bits'(queue_depth - 1) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr == queue_ptr_bits'(queue_depth - 1) ? '0 : rd_ptr + 1'b1;

            case ({in_valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase

            // one credit back to the sender for every entry consumed
            in_credit <= pop;
        end
    end

    // a sender that honours its credits never pushes into a full queue
    assert property (@(posedge clk) disable iff (reset)
        in_valid |-> count != (queue_ptr_bits + 1)'(queue_depth));

endmodule

//--- hdl/ucode_rom.sv
`timescale 1ns/1ps

module ucode_rom
    import ucode_pkg::*;
(
    input logic clk,
    input logic [addr_bits-1:0] next_addr,
    output ucode_word_t word
);

    function automatic ucode_word_t entry(input logic [addr_bits-1:0] a);
        ucode_word_t w;
        w = '0;
        w.next = fetch_address;
        w.jump_type = JUMP_UNCOND;
        w.alu_op = ALU_PASS_B;
        w.next_instruction = 1'b1;
        case (a)
            // wait here until the queue has an instruction
            6'h00: begin
                w.jump_type = JUMP_DISPATCH;
                w.next_instruction = 1'b0;
            end
            6'h01: begin
                w.b_imm = 1'b1;
                w.rd_write = 1'b1;
            end
            6'h02: begin
                w.alu_op = ALU_ADD;
                w.rd_write = 1'b1;
            end
            6'h03: begin
                w.alu_op = ALU_SUB;
                w.rd_write = 1'b1;
            end
            6'h04: begin
                w.alu_op = ALU_AND;
                w.rd_write = 1'b1;
            end
            6'h05: begin
                w.alu_op = ALU_XOR;
                w.rd_write = 1'b1;
            end
            // shl, load the count then loop one bit per step
            6'h06: begin
                w.count_load = 1'b1;
                w.jump_type = JUMP_COUNT_ZERO;
                w.next = shl_loop_address;
            end
            6'h07: w.out_write = 1'b1;
            6'h08: begin
                w.alu_op = ALU_SHL1;
                w.rd_write = 1'b1;
                w.jump_type = JUMP_COUNT_ZERO;
                w.next = shl_loop_address;
            end
            6'h10: w.fault = 1'b1;
            default: w.next = fetch_address;
        endcase
        return w;
    endfunction

    always_ff @(posedge clk)
        word <= entry(next_addr);

endmodule

//--- hdl/alu_regs.sv
`timescale 1ns/1ps

module alu_regs
    import isa_pkg::*;
    import ucode_pkg::*;
(
    input logic clk,
    input logic reset,
    input alu_op_t alu_op,
    input logic b_imm,
    input logic rd_write,
    input logic count_load,
    input logic [reg_bits-1:0] rd,
    input logic [reg_bits-1:0] rs,
    input logic [data_bits-1:0] imm,
    output logic [data_bits-1:0] rd_value,
    output logic count_zero
);

    logic [data_bits-1:0] regs [num_regs];
    logic [data_bits-1:0] a;
    logic [data_bits-1:0] b;
    logic [data_bits-1:0] result;
    logic [data_bits-1:0] count;
    logic [data_bits-1:0] count_d;

    assign a = regs[rd];
    assign b = b_imm ? imm : regs[rs];
    assign rd_value = a;

    // results wrap at 8 bits
    always_comb begin
        case (alu_op)
            ALU_PASS_B: result = b;
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_XOR: result = a ^ b;
            ALU_SHL1: result = {a[data_bits-2:0], 1'b0};
            default: result = b;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (rd_write) begin
            regs[rd] <= result;
        end
    end

    // shift counter, one decrement per shift step
    always_comb begin
        if (count_load)
            count_d = imm;
        else if (alu_op == ALU_SHL1 && count != '0)
            count_d = count - 1'b1;
        else
            count_d = count;
    end

    // looks at the value after this step so the last shift also exits the loop
    assign count_zero = count_d == '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            count <= '0;
        else
            count <= count_d;
    end

endmodule

//--- hdl/ucode_sequencer.sv
`timescale 1ns/1ps

module ucode_sequencer
    import isa_pkg::*;
    import ucode_pkg::*;
(
    input logic clk,
    input logic reset,
    input instr_t head,
    input logic head_valid,
    output logic pop,
    input ucode_word_t word,
    output logic [addr_bits-1:0] next_addr,
    input logic count_zero,
    input logic out_credit,
    output logic out_valid,
    output logic fault,
    output logic [opcode_bits-1:0] cur_opcode,
    output logic [reg_bits-1:0] cur_rd,
    output logic [reg_bits-1:0] cur_rs,
    output logic [data_bits-1:0] cur_imm
);

    instr_t cur_instr;
    logic [addr_bits-1:0] addr;
    logic [credit_bits-1:0] credits;
    logic have_credit;
    logic out_stall;
    logic opcode_valid;

    assign have_credit = credits != '0;
    assign out_stall = word.out_write && !have_credit;
    assign out_valid = word.out_write && have_credit;
    assign fault = word.fault;

    assign opcode_valid = head.opcode >= OP_LDI && head.opcode <= OP_OUT;

    // start a new instruction from the fetch word
    assign pop = word.jump_type == JUMP_DISPATCH && head_valid;

    always_comb begin
        if (reset)
            next_addr = fetch_address;
        else if (out_stall)
            next_addr = addr;
        else if (pop)
            next_addr = opcode_valid ? head.opcode[addr_bits-1:0] : bad_opcode_address;
        else if (word.jump_type == JUMP_COUNT_ZERO)
            next_addr = count_zero ? fetch_address : word.next;
        else if (word.next_instruction)
            next_addr = fetch_address;
        else
            next_addr = word.next;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            addr <= fetch_address;
        else
            addr <= next_addr;
    end

    always_ff @(posedge clk) begin
        if (pop)
            cur_instr <= head;
    end

    assign cur_opcode = cur_instr.opcode;
    assign cur_rd = cur_instr.rd;
    assign cur_rs = cur_instr.rs;
    assign cur_imm = cur_instr.imm;

    // output link credits, one back per out_credit pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= credit_bits'(out_credits);
        end else begin
            case ({out_credit, out_valid})
                2'b10: credits <= credits + 1'b1;
                2'b01: credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // receiver never hands back more than it was given
    assert property (@(posedge clk) disable iff (reset)
        credits <= credit_bits'(out_credits));

    // only the fetch microinstruction dispatches
    assert property (@(posedge clk) disable iff (reset)
        pop |-> addr == fetch_address);

endmodule

//--- hdl/microcoded_core.sv
`timescale 1ns/1ps

module microcoded_core
    import isa_pkg::*;
    import ucode_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic in_valid,
    input instr_t in_instr,
    output logic in_credit,
    output logic out_valid,
    output logic [data_bits-1:0] out_data,
    input logic out_credit,
    output logic fault
);

    instr_t head;
    logic head_valid;
    logic pop;
    ucode_word_t word;
    logic [addr_bits-1:0] next_addr;
    logic count_zero;
    logic [reg_bits-1:0] cur_rd;
    logic [reg_bits-1:0] cur_rs;
    logic [data_bits-1:0] cur_imm;

    instr_queue u_queue (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_instr(in_instr),
        .in_credit(in_credit),
        .head(head),
        .head_valid(head_valid),
        .pop(pop)
    );

    ucode_sequencer u_sequencer (
        .clk(clk),
        .reset(reset),
        .head(head),
        .head_valid(head_valid),
        .pop(pop),
        .word(word),
        .next_addr(next_addr),
        .count_zero(count_zero),
        .out_credit(out_credit),
        .out_valid(out_valid),
        .fault(fault),
        .cur_opcode(),
        .cur_rd(cur_rd),
        .cur_rs(cur_rs),
        .cur_imm(cur_imm)
    );

    ucode_rom u_rom (
        .clk(clk),
        .next_addr(next_addr),
        .word(word)
    );

    // out_data is the rd register of the OUT instruction
    alu_regs u_alu_regs (
        .clk(clk),
        .reset(reset),
        .alu_op(word.alu_op),
        .b_imm(word.b_imm),
        .rd_write(word.rd_write),
        .count_load(word.count_load),
        .rd(cur_rd),
        .rs(cur_rs),
        .imm(cur_imm),
        .rd_value(out_data),
        .count_zero(count_zero)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

//--- bench/core_tb.sv
`timescale 1ns/1ps

module core_tb
    import isa_pkg::*;
();

    localparam time drive_delay = 5ns;
    localparam int max_instr = 128;

    logic clk;
    logic reset;
    logic in_valid;
    instr_t in_instr;
    logic in_credit;
    logic out_valid;
    logic [data_bits-1:0] out_data;
    logic out_credit;
    logic fault;

    integer seed = 32'haf723f9d;
    instr_t prog [max_instr];
    logic [data_bits-1:0] model [num_regs];
    logic [data_bits-1:0] expected_data [max_instr];
    int expected_faults [max_instr];
    int prog_len = 0;
    int num_outs = 0;
    int bad_count = 0;
    int sent = 0;
    int timeout_cycles = 200;
    int cycle_count = 0;
    int hold_cycles = 0;
    int holds_done = 0;
    int credit_gap = 0;
    int tx_credits;
    int rx_credits;
    int out_count;
    int fault_count;
    int credit_pulses;
    logic [data_bits-1:0] expected_now;
    int expected_faults_now;

    tb_clock u_clock (.clk(clk));

    microcoded_core u_dut (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_instr(in_instr),
        .in_credit(in_credit),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_credit(out_credit),
        .fault(fault)
    );

    task automatic report_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // append one instruction and advance the register model in program order
    task automatic add_instr(input logic [opcode_bits-1:0] op, input int rd, input int rs,
                             input logic [data_bits-1:0] imm);
        instr_t instr;
        instr.opcode = op;
        instr.rd = reg_bits'(rd);
        instr.rs = reg_bits'(rs);
        instr.imm = imm;
        prog[prog_len] = instr;
        prog_len++;
        case (op)
            OP_LDI: model[rd] = imm;
            OP_ADD: model[rd] = model[rd] + model[rs];
            OP_SUB: model[rd] = model[rd] - model[rs];
            OP_AND: model[rd] = model[rd] & model[rs];
            OP_XOR: model[rd] = model[rd] ^ model[rs];
            // bits shifted past bit 7 are lost
            OP_SHL: model[rd] = imm > 7 ? '0 : model[rd] << imm;
            OP_OUT: begin
                expected_data[num_outs] = model[rd];
                expected_faults[num_outs] = bad_count;
                num_outs++;
            end
            default: bad_count++;
        endcase
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [opcode_bits-1:0] op;
        // registers come out of reset at zero
        add_instr(OP_OUT, 0, 0, 0);
        add_instr(OP_OUT, 3, 0, 0);
        add_instr(OP_LDI, 0, 0, 8'h5a);
        add_instr(OP_OUT, 0, 0, 0);
        add_instr(OP_LDI, 1, 0, 8'hc3);
        add_instr(OP_LDI, 2, 0, 8'h7f);
        add_instr(OP_ADD, 1, 2, 0);
        add_instr(OP_OUT, 1, 0, 0);
        add_instr(OP_SUB, 2, 0, 0);
        add_instr(OP_OUT, 2, 0, 0);
        add_instr(OP_AND, 1, 0, 0);
        add_instr(OP_OUT, 1, 0, 0);
        add_instr(OP_XOR, 0, 2, 0);
        add_instr(OP_OUT, 0, 0, 0);
        for (int c = 0; c < 10; c++) begin
            add_instr(OP_LDI, 3, 0, 8'hb7);
            add_instr(OP_SHL, 3, 0, 8'(c));
            add_instr(OP_OUT, 3, 0, 0);
        end
        // invalid opcodes must leave r1 alone
        add_instr(8'h00, 1, 2, 8'h11);
        add_instr(OP_OUT, 1, 0, 0);
        add_instr(8'h08, 1, 1, 8'h22);
        add_instr(OP_OUT, 1, 0, 0);
        add_instr(8'hff, 1, 0, 8'h33);
        add_instr(8'h47, 1, 3, 8'h44);
        add_instr(OP_OUT, 1, 0, 0);
        for (int i = 0; i < 48; i++) begin
            r = $random(seed);
            if (r[4:0] == 5'd0)
                op = r[31] ? 8'h00 : {1'b1, r[30:24]};
            else
                op = 8'(1 + r[7:4] % 7);
            add_instr(op, r[9:8], r[11:10], op == OP_SHL ? 8'(r[19:16] % 12) : r[23:16]);
        end
        for (int i = 0; i < num_regs; i++)
            add_instr(OP_OUT, i, 0, 0);
    endtask

    // sends while a credit is held, with random idle cycles
    task automatic drive_sender();
        logic [31:0] r;
        r = $random(seed);
        in_valid = 1'b0;
        in_instr = '0;
        if (sent < prog_len && tx_credits > 0 && r[1:0] != 2'b00) begin
            in_valid = 1'b1;
            in_instr = prog[sent];
            sent++;
        end
    endtask

    // returns credits after a random gap, and withholds them twice for a long stretch
    task automatic drive_receiver();
        out_credit = 1'b0;
        if ((holds_done == 0 && out_count >= 4) || (holds_done == 1 && out_count >= 24)) begin
            hold_cycles = 60;
            holds_done++;
        end
        if (hold_cycles > 0) begin
            hold_cycles--;
        end else if (credit_gap > 0) begin
            credit_gap--;
        end else if (rx_credits < out_credits) begin
            out_credit = 1'b1;
            credit_gap = $random(seed) & 3;
        end
    endtask

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_credits <= queue_depth;
            rx_credits <= out_credits;
            out_count <= 0;
            fault_count <= 0;
            credit_pulses <= 0;
        end else begin
            tx_credits <= tx_credits + int'(in_credit) - int'(in_valid);
            rx_credits <= rx_credits + int'(out_credit) - int'(out_valid);
            out_count <= out_count + int'(out_valid);
            fault_count <= fault_count + int'(fault);
            credit_pulses <= credit_pulses + int'(in_credit);
        end
    end

    assign expected_now = expected_data[out_count];
    assign expected_faults_now = expected_faults[out_count];

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
            report_error($sformatf("timeout after %0d cycles, %0d of %0d results received",
                cycle_count, out_count, num_outs));
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_data == expected_now)
        else report_error($sformatf("FAIL out_data: got %h expected %h",
            $sampled(out_data), $sampled(expected_now)));

    // faults arrive in program order relative to the OUT results
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> fault_count == expected_faults_now)
        else report_error($sformatf("FAIL fault count at out_valid: got %h expected %h",
            $sampled(fault_count), $sampled(expected_faults_now)));

    assert property (@(posedge clk) disable iff (reset) out_valid |-> out_count < num_outs)
        else report_error("out_valid raised after every expected result had arrived");

    assert property (@(posedge clk) disable iff (reset) fault |=> !fault)
        else report_error("fault stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (reset) fault |-> fault_count < bad_count)
        else report_error("fault raised more often than invalid opcodes were sent");

    assert property (@(posedge clk) disable iff (reset) out_valid |-> rx_credits > 0)
        else report_error("out_valid raised while the core held no output credit");

    assert property (@(posedge clk) disable iff (reset) tx_credits <= queue_depth)
        else report_error("in_credit returned more credits than instructions were sent");

    assert property (@(posedge clk) $fell(reset) |-> !out_valid && !fault && !in_credit)
        else report_error("outputs were not idle when reset was released");

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        out_credit = 1'b0;
        for (int i = 0; i < num_regs; i++)
            model[i] = '0;
        build_program();
        timeout_cycles = 40 * prog_len + 200;

        repeat (16) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        while (!(sent == prog_len && out_count == num_outs && tx_credits == queue_depth
                 && rx_credits == out_credits)) begin
            @(posedge clk);
            #drive_delay;
            drive_sender();
            drive_receiver();
        end
        repeat (4) @(posedge clk);

        if (credit_pulses == sent && tx_credits == queue_depth && fault_count == bad_count)
        begin
            $display("** PASS **");
            $finish;
        end else begin
            if (credit_pulses != sent)
                report_error($sformatf("FAIL in_credit pulses: got %h expected %h",
                    credit_pulses, sent));
            else if (tx_credits != queue_depth)
                report_error($sformatf("FAIL sender credits: got %h expected %h",
                    tx_credits, queue_depth));
            else
                report_error($sformatf("FAIL fault pulses: got %h expected %h",
                    fault_count, bad_count));
        end
    end

endmodule

//--- src.f
hdl/isa_pkg.sv
hdl/ucode_pkg.sv
hdl/instr_queue.sv
hdl/ucode_rom.sv
hdl/alu_regs.sv
hdl/ucode_sequencer.sv
hdl/microcoded_core.sv
bench/tb_clock.sv
bench/core_tb.sv

//--- Bender.yml
package:
  name: microcoded_core

sources:
  - hdl/isa_pkg.sv
  - hdl/ucode_pkg.sv
  - hdl/instr_queue.sv
  - hdl/ucode_rom.sv
  - hdl/alu_regs.sv
  - hdl/ucode_sequencer.sv
  - hdl/microcoded_core.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/core_tb.sv
